// File: Makefile
VERILATOR ?= verilator
TB_TOP ?= camera_control_tb
RTL_TOP ?= camera_control
FILE_LIST ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --timing --assert
RTL_FILES ?= source/camera_pkg.sv source/key_sampler.sv source/motion_fifo.sv \
             source/camera_integrator.sv source/camera_control.sv

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only +incdir+include --top-module $(RTL_TOP) $(RTL_FILES)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILE_LIST) --top-module $(TB_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILE_LIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o $(TB_TOP)

sim: build
	@out="$$(./$(BUILD_DIR)/$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(BUILD_DIR)

// File: include/fp_arith.svh
`ifndef FP_ARITH_SVH
`define FP_ARITH_SVH

// Q4.12 helpers, expects fp and fp_frac_bits in scope

function automatic fp fp_add(input fp a, input fp b);
  return a + b;
endfunction

function automatic fp fp_sub(input fp a, input fp b);
  return a - b;
endfunction

function automatic fp fp_neg(input fp a);
  return -a;
endfunction

// Full product, then drop the low fraction bits (rounds toward minus infinity)
function automatic fp fp_mul(input fp a, input fp b);
  logic signed [2*$bits(fp)-1:0] prod;
  prod = (2 * $bits(fp))'(a) * (2 * $bits(fp))'(b);
  return prod[fp_frac_bits +: $bits(fp)];
endfunction

`endif

// File: source/camera_control.sv
`timescale 1ns/100ps

module camera_control import camera_pkg::*; #(
  parameter int tick_shift = 3,
  parameter int fifo_depth = 4
) (
  input  logic         clk_in,
  input  logic         rst_in,
  input  logic         btnl,
  input  logic         btnr,
  input  logic         btnu,
  input  logic         btnd,
  input  key_set_t     kb_in,
  input  logic         walk_mode,
  input  speed_t       speed,
  input  logic         frame_busy,
  output camera_pose_t pose,
  output logic         pose_valid
);

  logic cmd_valid;
  logic cmd_ready;
  motion_cmd_t cmd;
  logic q_valid;
  logic q_ready;
  motion_cmd_t q_cmd;

  key_sampler #(
    .tick_shift(tick_shift)
  ) i_sampler (
    .clk_in(clk_in), .rst_in(rst_in),
    .btnl(btnl), .btnr(btnr), .btnu(btnu), .btnd(btnd),
    .kb_in(kb_in), .walk_mode(walk_mode), .speed(speed),
    .cmd_valid(cmd_valid), .cmd(cmd), .cmd_ready(cmd_ready)
  );

  motion_fifo #(
    .depth(fifo_depth)
  ) i_fifo (
    .clk_in(clk_in), .rst_in(rst_in),
    .in_valid(cmd_valid), .in_cmd(cmd), .in_ready(cmd_ready),
    .out_valid(q_valid), .out_cmd(q_cmd), .out_ready(q_ready)
  );

  camera_integrator i_integrator (
    .clk_in(clk_in), .rst_in(rst_in),
    .in_valid(q_valid), .in_cmd(q_cmd), .in_ready(q_ready),
    .frame_busy(frame_busy), .pose(pose), .pose_valid(pose_valid)
  );

endmodule

// File: source/camera_integrator.sv
`timescale 1ns/100ps

module camera_integrator import camera_pkg::*; (
  input  logic         clk_in,
  input  logic         rst_in,
  input  logic         in_valid,
  input  motion_cmd_t  in_cmd,
  output logic         in_ready,
  input  logic         frame_busy,
  output camera_pose_t pose,
  output logic         pose_valid
);

  integ_state_t state;
  motion_cmd_t cur_cmd;
  logic parity; // Low walks, high strafes
  camera_pose_t next_pose;
  fp step_x;
  fp step_z;
  fp sin_term;

  assign in_ready = (state == idle) & ~frame_busy;

  // Pose update from the held command, all terms use the old pose
  always_comb begin
    next_pose = pose;
    step_x = fp_mul(pose.dir.x, fp_hundredth);
    step_z = fp_mul(pose.dir.z, fp_hundredth);
    sin_term = cur_cmd.turn_left ? fp_neg(fp_sin_hundredth) : fp_sin_hundredth;

    if (cur_cmd.up) begin
      next_pose.pos.y = fp_add(pose.pos.y, fp_step);
    end else if (cur_cmd.down) begin
      next_pose.pos.y = fp_sub(pose.pos.y, fp_step);
    end

    if (!parity) begin
      if (cur_cmd.fwd) begin
        next_pose.pos.x = fp_add(pose.pos.x, step_x);
        next_pose.pos.z = fp_add(pose.pos.z, step_z);
      end else if (cur_cmd.back) begin
        next_pose.pos.x = fp_sub(pose.pos.x, step_x);
        next_pose.pos.z = fp_sub(pose.pos.z, step_z);
      end
    end else begin
      // Strafe is perpendicular to dir in the xz plane
      if (cur_cmd.left) begin
        next_pose.pos.x = fp_sub(pose.pos.x, step_z);
        next_pose.pos.z = fp_add(pose.pos.z, step_x);
      end else if (cur_cmd.right) begin
        next_pose.pos.x = fp_add(pose.pos.x, step_z);
        next_pose.pos.z = fp_sub(pose.pos.z, step_x);
      end
    end

    if (cur_cmd.turn_left || cur_cmd.turn_right) begin
      next_pose.dir.x = fp_add(fp_mul(pose.dir.x, fp_cos_hundredth),
                               fp_mul(pose.dir.z, sin_term));
      next_pose.dir.z = fp_add(fp_mul(pose.dir.x, fp_neg(sin_term)),
                               fp_mul(pose.dir.z, fp_cos_hundredth));
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state <= idle;
      parity <= 1'b0;
      pose_valid <= 1'b0;
      pose.pos <= pos_reset;
      pose.dir <= dir_reset;
    end else begin
      pose_valid <= 1'b0;
      case (state)
        idle: begin
          if (in_valid && in_ready) begin
            state <= apply;
          end
        end
        apply: begin
          pose <= next_pose;
          pose_valid <= 1'b1; // One cycle strobe
          parity <= ~parity;
          state <= idle;
        end
        default: state <= idle;
      endcase
    end
  end

  // Command payload, taken on the pop
  always_ff @(posedge clk_in) begin
    if (in_valid && in_ready) begin
      cur_cmd <= in_cmd;
    end
  end

endmodule

// File: source/camera_pkg.sv
package camera_pkg;

  // Q4.12 signed fixed point
  localparam int fp_frac_bits = 12;

  typedef logic signed [15:0] fp;

  typedef struct packed {
    fp x;
    fp y;
    fp z;
  } vec3;

  `include "fp_arith.svh"

  localparam fp fp_one = fp'(1 << fp_frac_bits);
  localparam fp fp_zero = fp'(0);
  localparam fp fp_step = fp_one >>> 7;
  localparam fp fp_hundredth = fp'(41);
  localparam fp fp_sin_hundredth = fp'(41);
  localparam fp fp_cos_hundredth = fp'(4096); // Rounds to one in Q4.12

  typedef logic [7:0] key_set_t;
  typedef logic [1:0] speed_t;

  // Bit positions in key_set_t
  localparam int kb_forward = 7;
  localparam int kb_backward = 6;
  localparam int kb_turn_left = 5;
  localparam int kb_turn_right = 4;
  localparam int kb_trans_up = 3;
  localparam int kb_trans_down = 2;
  localparam int kb_trans_left = 1;
  localparam int kb_trans_right = 0;

  // Resolved flags, same order as the key bits
  typedef struct packed {
    logic fwd;
    logic back;
    logic turn_left;
    logic turn_right;
    logic up;
    logic down;
    logic left;
    logic right;
  } motion_cmd_t;

  typedef struct packed {
    vec3 pos;
    vec3 dir;
  } camera_pose_t;

  localparam vec3 pos_reset = '{
    x: fp_zero,
    y: fp_one,
    z: fp'(-(fp_one + (fp_one >>> 1))) // -1.5
  };

  localparam vec3 dir_reset = '{x: fp_zero, y: fp_zero, z: fp_one};

  typedef enum logic {
    idle,
    apply
  } integ_state_t;

endpackage

// File: source/key_sampler.sv
`timescale 1ns/100ps

module key_sampler import camera_pkg::*; #(
  parameter int tick_shift = 3
) (
  input  logic        clk_in,
  input  logic        rst_in,
  input  logic        btnl,
  input  logic        btnr,
  input  logic        btnu,
  input  logic        btnd,
  input  key_set_t    kb_in,
  input  logic        walk_mode,
  input  speed_t      speed,
  output logic        cmd_valid,
  output motion_cmd_t cmd,
  input  logic        cmd_ready
);

  // One spare bit so (speed+1) << tick_shift never wraps
  localparam int cnt_w = tick_shift + 3;

  key_set_t keys;
  motion_cmd_t resolved;
  logic [cnt_w-1:0] tick_cnt;
  logic [cnt_w-1:0] tick_last;
  logic tick;
  logic slot_free;

  // Buttons land on walk keys or translate keys
  always_comb begin
    if (walk_mode) begin
      keys = kb_in | {btnu, btnd, btnl, btnr, 4'b0000};
    end else begin
      keys = kb_in | {4'b0000, btnu, btnd, btnl, btnr};
    end
  end

  // Opposing pairs cancel, turn left wins a tie
  always_comb begin
    resolved.fwd = keys[kb_forward] & ~keys[kb_backward];
    resolved.back = keys[kb_backward] & ~keys[kb_forward];
    resolved.turn_left = keys[kb_turn_left];
    resolved.turn_right = keys[kb_turn_right] & ~keys[kb_turn_left];
    resolved.up = keys[kb_trans_up] & ~keys[kb_trans_down];
    resolved.down = keys[kb_trans_down] & ~keys[kb_trans_up];
    resolved.left = keys[kb_trans_left] & ~keys[kb_trans_right];
    resolved.right = keys[kb_trans_right] & ~keys[kb_trans_left];
  end

  assign tick_last = ((cnt_w'(speed) + cnt_w'(1)) << tick_shift) - cnt_w'(1);
  assign tick = (tick_cnt >= tick_last); // Also catches a speed drop mid-count
  assign slot_free = ~cmd_valid | cmd_ready;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      tick_cnt <= '0;
    end else if (tick) begin
      tick_cnt <= '0;
    end else begin
      tick_cnt <= tick_cnt + cnt_w'(1);
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      cmd_valid <= 1'b0;
    end else begin
      if (cmd_valid && cmd_ready) begin
        cmd_valid <= 1'b0;
      end
      if (tick && slot_free && (|resolved)) begin
        cmd_valid <= 1'b1; // Sample dropped when the slot is still held
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (tick && slot_free) begin
      cmd <= resolved;
    end
  end

endmodule

// File: source/motion_fifo.sv
`timescale 1ns/100ps

module motion_fifo import camera_pkg::*; #(
  parameter int depth = 4
) (
  input  logic        clk_in,
  input  logic        rst_in,
  input  logic        in_valid,
  input  motion_cmd_t in_cmd,
  output logic        in_ready,
  output logic        out_valid,
  output motion_cmd_t out_cmd,
  input  logic        out_ready
);

  localparam int ptr_w = $clog2(depth);
  localparam int cnt_w = $clog2(depth + 1);
  localparam logic [ptr_w-1:0] last_ptr = ptr_w'(depth - 1);
  localparam logic [cnt_w-1:0] full_cnt = cnt_w'(depth);

  motion_cmd_t mem [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic push;
  logic pop;

  assign in_ready = (count != full_cnt);
  assign out_valid = (count != '0);
  assign out_cmd = mem[rd_ptr];

  assign push = in_valid & in_ready;
  assign pop = out_valid & out_ready;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + ptr_w'(1);
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + ptr_w'(1);
      end
      case ({push, pop})
        2'b10: count <= count + cnt_w'(1);
        2'b01: count <= count - cnt_w'(1);
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    if (push) begin
      mem[wr_ptr] <= in_cmd;
    end
  end

endmodule

// File: tb.f
+incdir+include
source/camera_pkg.sv
source/key_sampler.sv
source/motion_fifo.sv
source/camera_integrator.sv
source/camera_control.sv
tests/camera_control_checker.sv
tests/camera_control_tb.sv

// File: tests/camera_control_checker.sv
`timescale 1ns/100ps

module camera_control_checker import camera_pkg::*; #(
  parameter int fifo_depth = 4
) (
  input logic         clk_in,
  input logic         rst_in,
  input logic         cmd_valid,
  input logic         cmd_ready,
  input motion_cmd_t  cmd,
  input logic         q_valid,
  input logic         q_ready,
  input motion_cmd_t  q_cmd,
  input logic         frame_busy,
  input camera_pose_t pose,
  input logic         pose_valid
);

  int occ; // Queue occupancy seen from the handshakes
  int fail_count;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      occ <= 0;
    end else begin
      occ <= occ + ((cmd_valid && cmd_ready) ? 1 : 0) - ((q_valid && q_ready) ? 1 : 0);
    end
  end

  initial fail_count = 0;

  cmd_hold: assert property (@(posedge clk_in) disable iff (rst_in)
    cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd))
    else begin
      fail_count++;
      $error("sampler dropped or changed a waiting command");
    end

  q_hold: assert property (@(posedge clk_in) disable iff (rst_in)
    q_valid && !q_ready |=> q_valid && $stable(q_cmd))
    else begin
      fail_count++;
      $error("queue dropped or changed its head command");
    end

  no_push_full: assert property (@(posedge clk_in) disable iff (rst_in)
    !(cmd_valid && cmd_ready && occ >= fifo_depth))
    else begin
      fail_count++;
      $error("push into a full queue");
    end

  // Every pose comes from a pop two edges back, taken while the renderer was free
  no_pop_busy: assert property (@(posedge clk_in) disable iff (rst_in)
    pose_valid |-> $past(q_valid && q_ready, 2) && $past(!frame_busy, 2))
    else begin
      fail_count++;
      $error("pose_valid without a pop made while the renderer was free");
    end

  pose_with_strobe: assert property (@(posedge clk_in) disable iff (rst_in)
    !$stable(pose) |-> pose_valid)
    else begin
      fail_count++;
      $error("pose changed without pose_valid");
    end

endmodule

bind camera_control camera_control_checker #(
  .fifo_depth(fifo_depth)
) i_checker (
  .clk_in(clk_in), .rst_in(rst_in),
  .cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd(cmd),
  .q_valid(q_valid), .q_ready(q_ready), .q_cmd(q_cmd),
  .frame_busy(frame_busy), .pose(pose), .pose_valid(pose_valid)
);

// File: tests/camera_control_tb.sv
`timescale 1ns/100ps

module camera_control_tb import camera_pkg::*; ();

  localparam int tick_shift = 3;
  localparam int fifo_depth = 4;
  localparam int drain_max = 200;
  localparam int phase_total = 60 + 400 + 400 + 100 + 4 * 300 + 800;
  localparam int timeout_limit = phase_total + 9 * drain_max + 100;

  logic clk_in;
  logic rst_in;
  logic btnl;
  logic btnr;
  logic btnu;
  logic btnd;
  key_set_t kb_in;
  logic walk_mode;
  speed_t speed;
  logic frame_busy;
  camera_pose_t pose;
  logic pose_valid;

  camera_control #(
    .tick_shift(tick_shift),
    .fifo_depth(fifo_depth)
  ) i_dut (
    .clk_in(clk_in), .rst_in(rst_in),
    .btnl(btnl), .btnr(btnr), .btnu(btnu), .btnd(btnd),
    .kb_in(kb_in), .walk_mode(walk_mode), .speed(speed),
    .frame_busy(frame_busy), .pose(pose), .pose_valid(pose_valid)
  );

  initial clk_in = 1'b0;
  always #50 clk_in = ~clk_in;

  logic [31:0] rng;
  int errors;
  int checks;
  int cycles;
  string cur_test;

  // Model state
  int m_cnt;
  logic m_sv;
  motion_cmd_t m_scmd;
  motion_cmd_t m_q[$];
  logic m_apply;
  motion_cmd_t m_cur;
  logic m_par;
  camera_pose_t m_pose;
  camera_pose_t exp_poses[$];
  int nonempty_ticks;
  int discards;
  int pulses;
  int busy_run;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic fp model_mul(input fp a, input fp b);
    logic signed [31:0] p;
    p = 32'(a) * 32'(b);
    return fp'(p >>> 12); // Floor of the Q4.12 product
  endfunction

  function automatic motion_cmd_t resolve(input key_set_t k);
    motion_cmd_t c;
    c.fwd = k[7] & ~k[6];
    c.back = k[6] & ~k[7];
    c.turn_left = k[5];
    c.turn_right = k[4] & ~k[5];
    c.up = k[3] & ~k[2];
    c.down = k[2] & ~k[3];
    c.left = k[1] & ~k[0];
    c.right = k[0] & ~k[1];
    return c;
  endfunction

  function automatic camera_pose_t model_step(input camera_pose_t p, input motion_cmd_t c,
                                              input logic odd);
    camera_pose_t n;
    fp dx;
    fp dz;
    fp s;
    n = p;
    dx = model_mul(p.dir.x, fp_hundredth);
    dz = model_mul(p.dir.z, fp_hundredth);
    if (c.up) n.pos.y = p.pos.y + fp_step;
    else if (c.down) n.pos.y = p.pos.y - fp_step;
    if (!odd) begin
      if (c.fwd) begin
        n.pos.x = p.pos.x + dx;
        n.pos.z = p.pos.z + dz;
      end else if (c.back) begin
        n.pos.x = p.pos.x - dx;
        n.pos.z = p.pos.z - dz;
      end
    end else if (c.left) begin
      n.pos.x = p.pos.x - dz;
      n.pos.z = p.pos.z + dx;
    end else if (c.right) begin
      n.pos.x = p.pos.x + dz;
      n.pos.z = p.pos.z - dx;
    end
    if (c.turn_left || c.turn_right) begin
      s = c.turn_left ? fp'(-fp_sin_hundredth) : fp_sin_hundredth;
      n.dir.x = model_mul(p.dir.x, fp_cos_hundredth) + model_mul(p.dir.z, s);
      n.dir.z = model_mul(p.dir.x, fp'(-s)) + model_mul(p.dir.z, fp_cos_hundredth);
    end
    return n;
  endfunction

  function automatic logic model_idle();
    return m_q.size() == 0 && !m_sv && !m_apply && exp_poses.size() == 0;
  endfunction

  // Model runs on the values the DUT sees at this edge
  always @(posedge clk_in) begin
    key_set_t keys;
    motion_cmd_t res;
    camera_pose_t want;
    logic tick;
    logic push;
    logic pop;
    logic slot_free;
    if (rst_in) begin
      m_cnt = 0;
      m_sv = 1'b0;
      m_q.delete();
      m_apply = 1'b0;
      m_par = 1'b0;
      m_pose.pos = pos_reset;
      m_pose.dir = dir_reset;
      exp_poses.delete();
      busy_run = 0;
    end else begin
      if (pose_valid) begin
        pulses++;
        checks++;
        if (exp_poses.size() == 0) begin
          errors++;
          $display("Unexpected pose_valid with no command in flight [%s]", cur_test);
        end else begin
          want = exp_poses.pop_front();
          if (pose !== want) begin
            errors++;
            $display("** Error [%s] expected %h actual %h", cur_test, want, pose);
          end
        end
        if (busy_run >= 3) begin
          errors++;
          $display("pose_valid came during a long busy burst [%s]", cur_test);
        end
      end
      if (walk_mode) keys = kb_in | {btnu, btnd, btnl, btnr, 4'b0000};
      else keys = kb_in | {4'b0000, btnu, btnd, btnl, btnr};
      res = resolve(keys);
      tick = m_cnt >= (((int'(speed) + 1) << tick_shift) - 1);
      push = m_sv && m_q.size() < fifo_depth;
      pop = !m_apply && !frame_busy && m_q.size() > 0;
      slot_free = !m_sv || m_q.size() < fifo_depth;
      if (m_apply) begin
        m_pose = model_step(m_pose, m_cur, m_par);
        m_par = ~m_par;
        exp_poses.push_back(m_pose);
        m_apply = 1'b0;
      end else if (pop) begin
        m_cur = m_q.pop_front();
        m_apply = 1'b1;
      end
      if (push) begin
        m_q.push_back(m_scmd);
        m_sv = 1'b0;
      end
      if (tick && slot_free) begin
        m_scmd = res;
        if (|res) m_sv = 1'b1;
      end
      if (tick && (|res)) begin
        nonempty_ticks++;
        if (!slot_free) discards++;
      end
      m_cnt = tick ? 0 : m_cnt + 1;
      busy_run = frame_busy ? busy_run + 1 : 0;
    end
  end

  always @(posedge clk_in) begin
    cycles++;
    if (cycles >= timeout_limit) begin
      $display("Timeout: run exceeded %0d cycles in %s", timeout_limit, cur_test);
      $display("TEST FAIL");
      $finish;
    end
  end

  task automatic run_phase(input string name, input int len, input logic mode,
                           input speed_t spd, input key_set_t mask, input key_set_t force_keys,
                           input logic btn_en, input logic busy_en);
    int base_ticks;
    int base_pulses;
    int base_disc;
    int busy_left;
    int waited;
    @(negedge clk_in);
    cur_test = name;
    base_ticks = nonempty_ticks;
    base_pulses = pulses;
    base_disc = discards;
    busy_left = 0;
    repeat (len) begin
      @(posedge clk_in);
      rng = xorshift(rng);
      walk_mode <= mode;
      speed <= spd;
      kb_in <= (rng[7:0] & mask) | force_keys;
      btnl <= btn_en & rng[8];
      btnr <= btn_en & rng[9];
      btnu <= btn_en & rng[10];
      btnd <= btn_en & rng[11];
      if (busy_en && busy_left > 0) begin
        frame_busy <= 1'b1;
        busy_left--;
      end else if (busy_en && rng[31:27] == 5'd0) begin
        frame_busy <= 1'b1;
        busy_left = 30 + int'(rng[20:15]);
      end else begin
        frame_busy <= 1'b0;
      end
    end
    @(posedge clk_in);
    kb_in <= '0;
    {btnl, btnr, btnu, btnd} <= 4'b0000;
    frame_busy <= 1'b0;
    waited = 0;
    @(negedge clk_in);
    while (!model_idle() && waited < drain_max) begin
      @(negedge clk_in);
      waited++;
    end
    if (!model_idle()) begin
      errors++;
      $display("Pipeline did not drain after phase %s", name);
    end
    checks++;
    if (!busy_en && (pulses - base_pulses) != (nonempty_ticks - base_ticks)) begin
      errors++;
      $display("** Error [%s] expected %0d actual %0d", name,
               nonempty_ticks - base_ticks, pulses - base_pulses);
    end
    if (busy_en && discards == base_disc) begin
      errors++;
      $display("No tick was discarded while the queue was full in %s", name);
    end
  endtask

  initial begin
    rng = 32'h6f4d;
    errors = 0;
    checks = 0;
    cycles = 0;
    nonempty_ticks = 0;
    discards = 0;
    pulses = 0;
    cur_test = "reset";
    rst_in = 1'b1;
    {btnl, btnr, btnu, btnd} = 4'b0000;
    kb_in = '0;
    walk_mode = 1'b0;
    speed = '0;
    frame_busy = 1'b0;
    repeat (4) @(posedge clk_in);
    rst_in <= 1'b0;
    @(negedge clk_in);
    checks++;
    if (pose !== {pos_reset, dir_reset}) begin
      errors++;
      $display("** Error [reset] expected %h actual %h", {pos_reset, dir_reset}, pose);
    end
    run_phase("reset_idle", 60, 1'b0, 2'd0, 8'h00, 8'h00, 1'b0, 1'b0);
    run_phase("translate", 400, 1'b0, 2'd0, 8'h0f, 8'h00, 1'b1, 1'b0);
    run_phase("walk_turn", 400, 1'b1, 2'd1, 8'hf0, 8'h00, 1'b1, 1'b0);
    run_phase("turn_tie", 100, 1'b1, 2'd0, 8'h00, 8'h30, 1'b0, 1'b0);
    for (int s = 0; s < 4; s++) begin
      run_phase($sformatf("speed_%0d", s), 300, s[0], speed_t'(s), 8'hff, 8'h00, 1'b1, 1'b0);
    end
    run_phase("backpressure", 800, 1'b0, 2'd0, 8'hff, 8'h00, 1'b1, 1'b1);
    checks++;
    if (pose !== m_pose) begin
      errors++;
      $display("** Error [final_pose] expected %h actual %h", m_pose, pose);
    end
    errors += i_dut.i_checker.fail_count;
    $display("Checks: %0d, errors: %0d, discards: %0d", checks, errors, discards);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
